//--- source/cpuPkg.sv
package cpuPkg;

   // Instruction field widths
   localparam int OpcW   = 6;
   localparam int RegW   = 5;
   localparam int ImmW   = 16;
   localparam int AltW   = 11;
   localparam int InstrW = 32;

   // Field positions, opcode at the top
   localparam int OpcLsb = InstrW - OpcW;
   localparam int RdLsb  = OpcLsb - RegW;
   localparam int RaLsb  = RdLsb - RegW;
   localparam int RbLsb  = RaLsb - RegW;

   typedef logic [1:0]      selT;
   typedef logic [2:0]      aluT;
   typedef logic [RegW-1:0] regT;
   typedef logic [OpcW-1:0] opcT;

   // Opcodes, octal as in the ISA tables
   localparam opcT OpMul   = 6'o20;
   localparam opcT OpMulI  = 6'o30;
   localparam opcT OpBsf   = 6'o21;
   localparam opcT OpBsfI  = 6'o31;
   localparam opcT OpDiv   = 6'o22;
   localparam opcT OpShift = 6'o44;
   localparam opcT OpMov   = 6'o45;
   localparam opcT OpBru   = 6'o46;
   localparam opcT OpBruI  = 6'o56;
   localparam opcT OpBcc   = 6'o47;
   localparam opcT OpBccI  = 6'o57;
   localparam opcT OpImm   = 6'o54;
   localparam opcT OpRtd   = 6'o55;
   localparam opcT OpFsl   = 6'o33;
   localparam opcT OpLoadR = 6'o62;

   // Operand mux selects
   localparam selT SrcReg = 2'd0;
   localparam selT SrcFwd = 2'd1;
   localparam selT SrcRam = 2'd2;
   localparam selT SrcPc  = 2'd3;
   localparam selT SrcImm = 2'd3;   // Target mux shares code 3 with PC

   // Writeback destination
   localparam selT DstAlu    = 2'd0;
   localparam selT DstBranch = 2'd1;
   localparam selT DstMem    = 2'd2;
   localparam selT DstNone   = 2'd3;

   // ALU result select
   localparam aluT AluAdd   = 3'd0;
   localparam aluT AluLog   = 3'd1;
   localparam aluT AluShift = 3'd2;
   localparam aluT AluPass  = 3'd3;
   localparam aluT AluMul   = 3'd4;
   localparam aluT AluBsf   = 3'd5;
   localparam aluT AluDiv   = 3'd6;

   // Decode freeze for a barrel shift
   localparam int BsfStallCycles = 2;
   localparam int StallCntW      = $clog2(BsfStallCycles + 1);
   localparam logic [StallCntW-1:0] StallLast = StallCntW'(BsfStallCycles);

endpackage

//--- source/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf
   import cpuPkg::*;
();

   logic [InstrW-1:0] iReg;      // Word being decoded
   opcT               prevOpc;   // Fields of the word before it
   regT               prevRd;
   regT               prevRa;
   regT               prevRb;
   logic [ImmW-1:0]   prevImm;
   logic [AltW-1:0]   prevAlt;

   modport latch (
      output iReg, prevOpc, prevRd, prevRa, prevRb, prevImm, prevAlt
   );

   modport ctrl (
      input iReg, prevOpc, prevRd, prevRa, prevRb, prevImm, prevAlt
   );

endinterface

//--- source/instrLatch.sv
`timescale 1ns/1ps

module instrLatch
   import cpuPkg::*;
(
   input  logic              gclk,
   input  logic              grst,
   input  logic              decEn,
   input  logic [InstrW-1:0] instr,
   decodeIf.latch            dbus
);

   // Current word
   always_ff @(posedge gclk) begin
      if (grst) begin
         dbus.iReg <= '0;
      end else if (decEn) begin
         dbus.iReg <= instr;
      end
   end

   // Old current word split into fields as it moves down
   always_ff @(posedge gclk) begin
      if (grst) begin
         dbus.prevOpc <= '0;
         dbus.prevRd  <= '0;
         dbus.prevRa  <= '0;
         dbus.prevRb  <= '0;
         dbus.prevImm <= '0;
         dbus.prevAlt <= '0;
      end else if (decEn) begin
         dbus.prevOpc <= dbus.iReg[OpcLsb +: OpcW];
         dbus.prevRd  <= dbus.iReg[RdLsb +: RegW];
         dbus.prevRa  <= dbus.iReg[RaLsb +: RegW];
         dbus.prevRb  <= dbus.iReg[RbLsb +: RegW];
         dbus.prevImm <= dbus.iReg[ImmW-1:0];   // Overlaps rb and alt
         dbus.prevAlt <= dbus.iReg[AltW-1:0];
      end
   end

endmodule

//--- source/pipeCtrl.sv
`timescale 1ns/1ps

module pipeCtrl
   import cpuPkg::*;
(
   input  logic   gclk,
   input  logic   grst,
   input  logic   decEn,
   input  logic   skip,
   input  logic   interrupt,
   decodeIf.ctrl  dbus,
   output selT    srcSel,
   output selT    tgtSel,
   output selT    altSel,
   output aluT    aluSel,
   output selT    dstSel,
   output regT    wrReg,
   output logic   memAccess,
   output logic   memLoad,
   output logic   preStoreWe,
   output logic   forceMiss,
   output logic   stallReq
);

   // Opcode classes shared by current and previous word
   function automatic logic isLoad(opcT opc);
      return {opc[5:4], opc[2]} == 3'b110;
   endfunction

   function automatic logic isStore(opcT opc);
      return {opc[5:4], opc[2]} == 3'b111;
   endfunction

   function automatic logic isBru(opcT opc);
      return (opc == OpBru) || (opc == OpBruI);
   endfunction

   function automatic logic isBcc(opcT opc);
      return (opc == OpBcc) || (opc == OpBccI);
   endfunction

   // Forwarding chain for one operand register
   function automatic selT fwdSel(regT opReg, regT pendReg, selT pendDst, regT lateReg);
      logic pendHit;
      pendHit = (pendReg != '0) && (pendReg == opReg);
      if (pendHit && pendDst == DstMem) begin
         return SrcRam;
      end else if (pendHit && pendDst == DstAlu) begin
         return SrcFwd;
      end else if (lateReg == opReg) begin
         return SrcRam;                        // Already written back to RAM path
      end
      return SrcReg;
   endfunction

   opcT  curOpc;
   regT  curRa;
   regT  curRb;

   logic curBru;
   logic curBcc;
   logic curBra;
   logic curMov;
   logic curSft;
   logic curLog;
   logic curMul;
   logic curBsf;
   logic curDiv;

   logic prevGet;

   selT  dstNext;
   regT  wbNext;
   aluT  aluNext;

   assign curOpc = dbus.iReg[OpcLsb +: OpcW];
   assign curRa  = dbus.iReg[RaLsb +: RegW];
   assign curRb  = dbus.iReg[RbLsb +: RegW];

   // Interrupt turns the word into an absolute branch
   assign curBru = isBru(curOpc) || interrupt;
   assign curBcc = isBcc(curOpc) && !interrupt;
   assign curBra = (isBru(curOpc) && curRa[3]) || interrupt;

   assign curMov = (curOpc == OpMov);
   assign curSft = (curOpc == OpShift);
   assign curLog = ({curOpc[5:4], curOpc[2]} == 3'b100);
   assign curMul = (curOpc == OpMul) || (curOpc == OpMulI);
   assign curBsf = (curOpc == OpBsf) || (curOpc == OpBsfI);
   assign curDiv = (curOpc == OpDiv);

   assign prevGet = (dbus.prevOpc == OpFsl) && !dbus.prevRb[RegW-1];   // Put flag in rb msb

   // Destination of the previous word, cancelled by skip
   always_comb begin
      if (skip) begin
         dstNext = DstAlu;
         wbNext  = '0;
      end else begin
         if (isStore(dbus.prevOpc) || dbus.prevOpc == OpRtd || isBcc(dbus.prevOpc)) begin
            dstNext = DstNone;
         end else if (isLoad(dbus.prevOpc) || prevGet) begin
            dstNext = DstMem;
         end else if (isBru(dbus.prevOpc)) begin
            dstNext = DstBranch;
         end else begin
            dstNext = DstAlu;
         end
         wbNext = dbus.prevRd;
      end
   end

   // Operand muxes
   assign srcSel = (curBru || curBcc) ? SrcPc : fwdSel(curRa, wbNext, dstNext, wrReg);
   assign tgtSel = curOpc[3] ? SrcImm : fwdSel(curRb, wbNext, dstNext, wrReg);   // Imm form
   assign altSel = fwdSel(curRa, wbNext, dstNext, wrReg);

   always_comb begin
      if (curBra || curMov) begin
         aluNext = AluPass;
      end else if (curSft) begin
         aluNext = AluShift;
      end else if (curLog) begin
         aluNext = AluLog;
      end else if (curMul) begin
         aluNext = AluMul;
      end else if (curBsf) begin
         aluNext = AluBsf;
      end else if (curDiv) begin
         aluNext = AluDiv;
      end else begin
         aluNext = AluAdd;
      end
   end

   // One stage further down on each advance
   always_ff @(posedge gclk) begin
      if (grst) begin
         aluSel <= '0;
         dstSel <= '0;
         wrReg  <= '0;
      end else if (decEn) begin
         aluSel <= aluNext;
         dstSel <= dstNext;
         wrReg  <= wbNext;
      end
   end

   // Data memory strobes
   assign memAccess  = isLoad(curOpc) || isStore(curOpc);
   assign memLoad    = isLoad(curOpc);
   assign preStoreWe = isStore(dbus.prevOpc);
   assign forceMiss  = (dbus.prevOpc == OpLoadR) && dbus.prevAlt[0];

   assign stallReq = curBsf;   // Barrel shift needs extra cycles

endmodule

//--- source/stallSeq.sv
`timescale 1ns/1ps

module stallSeq
   import cpuPkg::*;
(
   input  logic gclk,
   input  logic grst,
   input  logic hold,
   input  logic stallReq,
   output logic decEn
);

   logic                 runQ;       // Low until first cycle out of reset
   logic [StallCntW-1:0] stallCnt;
   logic                 stallDone;

   assign stallDone = (stallCnt == StallLast);

   // Advance unless held or still waiting on a barrel shift
   assign decEn = runQ && !hold && (!stallReq || stallDone);

   always_ff @(posedge gclk) begin
      if (grst) begin
         runQ     <= 1'b0;
         stallCnt <= '0;
      end else begin
         runQ <= 1'b1;
         if (!hold) begin
            // Count stall cycles, clear on the releasing cycle
            if (stallReq && !stallDone) begin
               stallCnt <= stallCnt + 1'b1;
            end else begin
               stallCnt <= '0;
            end
         end
      end
   end

endmodule

//--- source/ctrlTop.sv
`timescale 1ns/1ps

module ctrlTop
   import cpuPkg::*;
(
   input  logic              gclk,
   input  logic              grst,
   input  logic [InstrW-1:0] instr,
   input  logic              skip,
   input  logic              interrupt,
   input  logic              hold,
   output logic              decEn,
   output selT               srcSel,
   output selT               tgtSel,
   output selT               altSel,
   output aluT               aluSel,
   output selT               dstSel,
   output regT               wrReg,
   output logic              memAccess,
   output logic              memLoad,
   output logic              preStoreWe,
   output logic              forceMiss,
   output logic              stallReq
);

   decodeIf dbus ();

   instrLatch uLatch (
      .gclk  (gclk),
      .grst  (grst),
      .decEn (decEn),
      .instr (instr),
      .dbus  (dbus.latch)
   );

   pipeCtrl uCtrl (
      .gclk       (gclk),
      .grst       (grst),
      .decEn      (decEn),
      .skip       (skip),
      .interrupt  (interrupt),
      .dbus       (dbus.ctrl),
      .srcSel     (srcSel),
      .tgtSel     (tgtSel),
      .altSel     (altSel),
      .aluSel     (aluSel),
      .dstSel     (dstSel),
      .wrReg      (wrReg),
      .memAccess  (memAccess),
      .memLoad    (memLoad),
      .preStoreWe (preStoreWe),
      .forceMiss  (forceMiss),
      .stallReq   (stallReq)
   );

   stallSeq uSeq (
      .gclk     (gclk),
      .grst     (grst),
      .hold     (hold),
      .stallReq (stallReq),
      .decEn    (decEn)
   );

endmodule

//--- dv/pipeCtrl_properties.sv
`timescale 1ns/1ps

module pipeCtrl_properties
   import cpuPkg::*;
(
   input logic gclk,
   input logic grst,
   input logic hold,
   input logic interrupt,
   input logic decEn,
   input logic stallReq,
   input selT  srcSel,
   input aluT  aluSel,
   input selT  dstSel,
   input regT  wrReg
);

   int stallLow;        // Stalled cycles since the last advance, hold cycles excluded
   int failCount = 0;   // Failed assertion attempts

   always_ff @(posedge gclk) begin
      if (grst || decEn) begin
         stallLow <= 0;
      end else if (stallReq && !hold) begin
         stallLow <= stallLow + 1;
      end
   end

   // Registered controls cleared by reset
   assert property (@(posedge gclk) grst |=> (aluSel == '0 && dstSel == '0 && wrReg == '0))
      else begin
         $error("aluSel, dstSel or wrReg not cleared after reset");
         failCount++;
      end

   assert property (@(posedge gclk) disable iff (grst) hold |-> !decEn)
      else begin
         $error("decEn high while hold is asserted");
         failCount++;
      end

   // Barrel shift releases only after the full stall
   assert property (@(posedge gclk) disable iff (grst)
                    (stallReq && decEn) |-> stallLow == BsfStallCycles)
      else begin
         $error("barrel shift stall length wrong");
         failCount++;
      end

   assert property (@(posedge gclk) disable iff (grst) interrupt |-> srcSel == SrcPc)
      else begin
         $error("srcSel not PC during interrupt");
         failCount++;
      end

endmodule

bind ctrlTop pipeCtrl_properties uProps (
   .gclk      (gclk),
   .grst      (grst),
   .hold      (hold),
   .interrupt (interrupt),
   .decEn     (decEn),
   .stallReq  (stallReq),
   .srcSel    (srcSel),
   .aluSel    (aluSel),
   .dstSel    (dstSel),
   .wrReg     (wrReg)
);

//--- dv/ctrlTb.sv
`timescale 1ns/1ps

module ctrlTb
   import cpuPkg::*;
();

   localparam int NumWords    = 600;
   localparam int ResetCycles = 3;
   localparam int ClkPeriod   = 100;
   localparam int WorstCycles = BsfStallCycles + 1 + 16;   // Stall plus a long hold burst

   logic              gclk;
   logic              grst;
   logic [InstrW-1:0] instr;
   logic              skip;
   logic              interrupt;
   logic              hold;
   logic              decEn;
   selT               srcSel;
   selT               tgtSel;
   selT               altSel;
   aluT               aluSel;
   selT               dstSel;
   regT               wrReg;
   logic              memAccess;
   logic              memLoad;
   logic              preStoreWe;
   logic              forceMiss;
   logic              stallReq;

   // Reference model state
   logic [InstrW-1:0] mCur;
   opcT               mPrevOpc;
   regT               mPrevRd;
   regT               mPrevRb;
   logic [AltW-1:0]   mPrevAlt;
   aluT               mAlu;
   selT               mDst;
   regT               mWr;
   logic              mRun;
   int                mCnt;

   // Expected values for the current cycle
   selT  eSrc, eTgt, eAlt, eDstNext;
   aluT  eAluNext;
   regT  eWbNext;
   logic eDecEn, eMemAcc, eMemLd, eStoreWe, eMiss, eStall;

   int selErrs  = 0;
   int aluErrs  = 0;
   int regErrs  = 0;
   int bitErrs  = 0;
   int propErrs = 0;
   int words    = 0;
   int cycle    = 0;

   logic [15:0] lfsrState = 16'd59501;

   opcT opList [0:14] = '{OpMul, OpMulI, OpBsf, OpBsfI, OpDiv, OpShift, OpMov, OpBru,
                          OpBruI, OpBcc, OpBccI, OpImm, OpRtd, OpFsl, OpLoadR};

   ctrlTop u_dut (.*);

   always #(ClkPeriod / 2) gclk = ~gclk;

   // Galois LFSR, one step per bit drawn
   function automatic logic [31:0] drawBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = {1'b0, lfsrState[15:1]} ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
         v = {v[30:0], lfsrState[0]};
      end
      return v;
   endfunction

   function automatic logic loadOp(opcT o);
      return o[5] && o[4] && !o[2];
   endfunction

   function automatic logic storeOp(opcT o);
      return o[5] && o[4] && o[2];
   endfunction

   function automatic logic uncondBr(opcT o);
      return (o == OpBru) || (o == OpBruI);
   endfunction

   function automatic logic condBr(opcT o);
      return (o == OpBcc) || (o == OpBccI);
   endfunction

   // Priority chain: pending memory, pending ALU, then the registered writeback
   function automatic selT forward(regT r, regT pend, selT pendDst, regT late);
      if (pend != '0 && pend == r && pendDst == DstMem) begin
         return SrcRam;
      end
      if (pend != '0 && pend == r && pendDst == DstAlu) begin
         return SrcFwd;
      end
      if (late == r) begin
         return SrcRam;
      end
      return SrcReg;
   endfunction

   task automatic checkSel(input string name, input selT exp, input selT act);
      if (act !== exp) begin
         selErrs++;
         $display("FAIL %0d ns %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic checkAlu(input string name, input aluT exp, input aluT act);
      if (act !== exp) begin
         aluErrs++;
         $display("FAIL %0d ns %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic checkReg(input string name, input regT exp, input regT act);
      if (act !== exp) begin
         regErrs++;
         $display("FAIL %0d ns %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic checkBit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         bitErrs++;
         $display("FAIL %0d ns %s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   task automatic resetModel();
      mCur     = '0;
      mPrevOpc = '0;
      mPrevRd  = '0;
      mPrevRb  = '0;
      mPrevAlt = '0;
      mAlu     = '0;
      mDst     = '0;
      mWr      = '0;
      mRun     = 1'b0;
      mCnt     = 0;
   endtask

   task automatic driveInputs();
      logic [31:0] word;
      logic [31:0] r;
      word = drawBits(InstrW);
      r = drawBits(5);   // Opcode pick in [3:0], bias flag in [4]
      if (r[4] && r[3:0] != 4'hF) begin
         word[31:26] = opList[r[3:0]];
      end
      r = drawBits(1);
      if (r[0]) begin   // Register numbers 0..3 so collisions are common
         word[25:23] = 3'b000;
         word[20:18] = 3'b000;
         word[15:13] = 3'b000;
      end
      instr = word;
      r = drawBits(3);
      skip = &r[2:0];
      r = drawBits(4);
      interrupt = &r[3:0];
      r = drawBits(3);
      hold = &r[2:0];
   endtask

   task automatic predict();
      opcT  opc;
      regT  ra;
      regT  rb;
      logic brAbs;
      logic fslGet;
      opc    = mCur[31:26];
      ra     = mCur[20:16];
      rb     = mCur[15:11];
      fslGet = (mPrevOpc == OpFsl) && !mPrevRb[4];   // FSL get, rb msb clear
      if (skip) begin
         eDstNext = '0;
         eWbNext  = '0;
      end else begin
         if (storeOp(mPrevOpc) || mPrevOpc == OpRtd || condBr(mPrevOpc)) begin
            eDstNext = DstNone;
         end else if (loadOp(mPrevOpc) || fslGet) begin
            eDstNext = DstMem;
         end else if (uncondBr(mPrevOpc)) begin
            eDstNext = DstBranch;
         end else begin
            eDstNext = DstAlu;
         end
         eWbNext = mPrevRd;
      end
      eAlt = forward(ra, eWbNext, eDstNext, mWr);
      eSrc = (interrupt || uncondBr(opc) || condBr(opc)) ? SrcPc : eAlt;
      eTgt = opc[3] ? SrcImm : forward(rb, eWbNext, eDstNext, mWr);
      brAbs = (uncondBr(opc) && ra[3]) || interrupt;
      if (brAbs || opc == OpMov)                   eAluNext = AluPass;
      else if (opc == OpShift)                     eAluNext = AluShift;
      else if (opc[5] && !opc[4] && !opc[2])       eAluNext = AluLog;
      else if (opc == OpMul || opc == OpMulI)      eAluNext = AluMul;
      else if (opc == OpBsf || opc == OpBsfI)      eAluNext = AluBsf;
      else if (opc == OpDiv)                       eAluNext = AluDiv;
      else                                         eAluNext = AluAdd;
      eStall   = (opc == OpBsf) || (opc == OpBsfI);
      eMemAcc  = loadOp(opc) || storeOp(opc);
      eMemLd   = loadOp(opc);
      eStoreWe = storeOp(mPrevOpc);
      eMiss    = (mPrevOpc == OpLoadR) && mPrevAlt[0];
      eDecEn   = mRun && !hold && (!eStall || mCnt == BsfStallCycles);
   endtask

   task automatic compareAll();
      checkBit("decEn", eDecEn, decEn);
      checkSel("srcSel", eSrc, srcSel);
      checkSel("tgtSel", eTgt, tgtSel);
      checkSel("altSel", eAlt, altSel);
      checkAlu("aluSel", mAlu, aluSel);
      checkSel("dstSel", mDst, dstSel);
      checkReg("wrReg", mWr, wrReg);
      checkBit("memAccess", eMemAcc, memAccess);
      checkBit("memLoad", eMemLd, memLoad);
      checkBit("preStoreWe", eStoreWe, preStoreWe);
      checkBit("forceMiss", eMiss, forceMiss);
      checkBit("stallReq", eStall, stallReq);
   endtask

   // State as it will be after the coming rising edge
   task automatic advance();
      if (grst) begin
         resetModel();
      end else begin
         if (eDecEn) begin
            mAlu     = eAluNext;
            mDst     = eDstNext;
            mWr      = eWbNext;
            mPrevOpc = mCur[31:26];
            mPrevRd  = mCur[25:21];
            mPrevRb  = mCur[15:11];
            mPrevAlt = mCur[10:0];
            mCur     = instr;
            words++;
         end
         if (!hold) begin
            mCnt = (eStall && mCnt != BsfStallCycles) ? mCnt + 1 : 0;
         end
         mRun = 1'b1;
      end
   endtask

   initial begin
      gclk      = 1'b0;
      grst      = 1'b1;
      instr     = '0;
      skip      = 1'b0;
      interrupt = 1'b0;
      hold      = 1'b0;
      resetModel();
      while (words < NumWords) begin
         @(negedge gclk);
         if (cycle >= ResetCycles - 1) begin
            grst = 1'b0;
         end
         driveInputs();
         #10;
         predict();
         compareAll();
         advance();
         cycle++;
      end
      propErrs = u_dut.uProps.failCount;   // Bound assertion failures
      $display("Summary: %0d select, %0d alu, %0d reg, %0d bit, %0d assert errors, %0d words",
               selErrs, aluErrs, regErrs, bitErrs, propErrs, words);
      if (selErrs + aluErrs + regErrs + bitErrs + propErrs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #((NumWords * WorstCycles + 20) * ClkPeriod);
      $display("Timeout: the watchdog expired before all words were decoded");
      $display("Errors found");
      $finish;
   end

endmodule

//--- flist.f
source/cpuPkg.sv
source/decodeIf.sv
source/instrLatch.sv
source/pipeCtrl.sv
source/stallSeq.sv
source/ctrlTop.sv
dv/pipeCtrl_properties.sv
dv/ctrlTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ctrlTb -f flist.f -o simv

./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

if grep -q "Errors found" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation passed"
